/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --timescale 1ns/100ps
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/100ps
TOP        := tb_cmac_core
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation did not pass, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+tests
hw/cmac_pkg.sv
hw/cmac_active.sv
hw/cmac_mac_cell.sv
hw/cmac_core.sv
tests/tb_clock_gen.sv
tests/tb_cmac_core.sv

/* hw/cmac_active.sv */
// no back-pressure; a weight must be sampled at least one cycle before the stripe_st atom of its stripe
`timescale 1ns/100ps

module cmac_active (
  input  logic                   nvdla_core_clk,
  input  logic                   reset,
  input  cmac_pkg::cmac_dat_in_t dat_in,
  input  cmac_pkg::cmac_wt_in_t  wt_in,
  output cmac_pkg::cmac_actv_t   actv [cmac_pkg::cmac_cells]
);

  // weight pre stage
  cmac_pkg::cmac_atom_t wt_pre_data;
  cmac_pkg::cmac_mask_t wt_pre_nz;
  cmac_pkg::cmac_sel_t  wt_pre_sel;

  // data pre stage
  cmac_pkg::cmac_atom_t dat_pre_data;
  cmac_pkg::cmac_mask_t dat_pre_nz;
  logic                 dat_pre_pvld;
  logic                 dat_pre_stripe_st;
  logic                 dat_pre_stripe_end;

  // stripe end one stage later, shared by all cells
  logic                 dat_actv_stripe_end;

  // ====================
  // weight input pipe
  // ====================

  // sel is qualified by pvld so an idle cycle never touches a shadow
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      wt_pre_nz  <= '0;
      wt_pre_sel <= '0;
    end else begin
      if (wt_in.pvld) begin
        wt_pre_nz <= wt_in.mask;
      end
      wt_pre_sel <= wt_in.sel & {cmac_pkg::cmac_cells{wt_in.pvld}};
    end
  end

  // only bytes with a set mask bit are loaded
  always_ff @(posedge nvdla_core_clk) begin
    for (int k = 0; k < cmac_pkg::cmac_atomc; k++) begin
      if (wt_in.pvld && wt_in.mask[k]) begin
        wt_pre_data.ch[k] <= wt_in.data.ch[k];
      end
    end
  end

  // ====================
  // data input pipe
  // ====================

  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      dat_pre_pvld        <= 1'b0;
      dat_pre_nz          <= '0;
      dat_pre_stripe_st   <= 1'b0;
      dat_pre_stripe_end  <= 1'b0;
      dat_actv_stripe_end <= 1'b0;
    end else begin
      dat_pre_pvld <= dat_in.pvld;
      if (dat_in.pvld) begin
        dat_pre_nz <= dat_in.mask;
      end
      // stripe flags only count on a valid atom
      dat_pre_stripe_st   <= dat_in.stripe_st & dat_in.pvld;
      dat_pre_stripe_end  <= dat_in.stripe_end & dat_in.pvld;
      dat_actv_stripe_end <= dat_pre_stripe_end;
    end
  end

  // zero channels keep whatever byte was there before
  always_ff @(posedge nvdla_core_clk) begin
    for (int k = 0; k < cmac_pkg::cmac_atomc; k++) begin
      if (dat_in.pvld && dat_in.mask[k]) begin
        dat_pre_data.ch[k] <= dat_in.data.ch[k];
      end
    end
  end

  // ====================
  // per-cell registers
  // ====================

  for (genvar i = 0; i < cmac_pkg::cmac_cells; i++) begin : g_cell
    // shadow set, filled from the weight pre stage
    cmac_pkg::cmac_atom_t wt_sd_data;
    cmac_pkg::cmac_mask_t wt_sd_nz;
    logic                 wt_sd_pvld;
    logic                 wt_sd_pvld_w;
    // active set, used by the current stripe
    cmac_pkg::cmac_atom_t wt_actv_data;
    cmac_pkg::cmac_mask_t wt_actv_nz;
    logic                 wt_actv_vld;
    logic                 wt_actv_vld_w;
    logic                 wt_actv_load;
    // second data stage, one copy per cell
    cmac_pkg::cmac_atom_t dat_actv_data;
    cmac_pkg::cmac_mask_t dat_actv_nz;
    logic                 dat_actv_pvld;

    // a new weight wins over the stripe start clear
    assign wt_sd_pvld_w = wt_pre_sel[i] ? 1'b1 :
                          dat_pre_stripe_st ? 1'b0 : wt_sd_pvld;

    // stripe start takes the shadow valid, the cycle after stripe end drops it
    assign wt_actv_vld_w = dat_pre_stripe_st ? wt_sd_pvld :
                           dat_actv_stripe_end ? 1'b0 : wt_actv_vld;

    // pop shadow into active only when the shadow holds a weight
    assign wt_actv_load = dat_pre_stripe_st & wt_sd_pvld;

    always_ff @(posedge nvdla_core_clk) begin
      if (reset) begin
        wt_sd_pvld    <= 1'b0;
        wt_sd_nz      <= '0;
        wt_actv_vld   <= 1'b0;
        wt_actv_nz    <= '0;
        dat_actv_pvld <= 1'b0;
        dat_actv_nz   <= '0;
      end else begin
        wt_sd_pvld  <= wt_sd_pvld_w;
        wt_actv_vld <= wt_actv_vld_w;
        if (wt_pre_sel[i]) begin
          wt_sd_nz <= wt_pre_nz;
        end
        if (wt_actv_load) begin
          wt_actv_nz <= wt_sd_nz;
        end
        dat_actv_pvld <= dat_pre_pvld;
        if (dat_pre_pvld) begin
          dat_actv_nz <= dat_pre_nz;
        end
      end
    end

    // payload bytes, byte enables follow the nz masks
    always_ff @(posedge nvdla_core_clk) begin
      for (int k = 0; k < cmac_pkg::cmac_atomc; k++) begin
        if (wt_pre_sel[i] && wt_pre_nz[k]) begin
          wt_sd_data.ch[k] <= wt_pre_data.ch[k];
        end
        // masked weight bytes are forced to zero on the way to active
        if (wt_actv_load) begin
          wt_actv_data.ch[k] <= wt_sd_nz[k] ? wt_sd_data.ch[k] : '0;
        end
        if (dat_pre_pvld && dat_pre_nz[k]) begin
          dat_actv_data.ch[k] <= dat_pre_data.ch[k];
        end
      end
    end

    assign actv[i] = '{
      dat_data:   dat_actv_data,
      dat_nz:     dat_actv_nz,
      wt_data:    wt_actv_data,
      wt_nz:      wt_actv_nz,
      pvld:       dat_actv_pvld & wt_actv_vld,
      stripe_end: dat_actv_stripe_end
    };
  end

endmodule

/* hw/cmac_core.sv */
// 3-cycle data to result latency; no handshake, so every stage takes an atom each cycle
`timescale 1ns/100ps

module cmac_core (
  input  logic                   nvdla_core_clk,
  input  logic                   reset,
  input  cmac_pkg::cmac_dat_in_t dat_in,
  input  cmac_pkg::cmac_wt_in_t  wt_in,
  output cmac_pkg::cmac_result_t result [cmac_pkg::cmac_cells]
);

  // operands from the activation stage, one bundle per cell
  cmac_pkg::cmac_actv_t actv [cmac_pkg::cmac_cells];

  // ====================
  // activation stage
  // ====================

  // pre stage and per-cell weight shadow and active sets
  cmac_active u_active (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .dat_in         (dat_in),
    .wt_in          (wt_in),
    .actv           (actv)
  );

  // ====================
  // mac cells
  // ====================

  // every cell sees the same data atom with its own weights
  for (genvar i = 0; i < cmac_pkg::cmac_cells; i++) begin : g_mac
    cmac_mac_cell u_mac_cell (
      .nvdla_core_clk (nvdla_core_clk),
      .reset          (reset),
      .actv           (actv[i]),
      .result         (result[i])
    );
  end

endmodule

/* hw/cmac_mac_cell.sv */
// full-precision 8-bit signed only; sum holds its last value while pvld is low
`timescale 1ns/100ps

module cmac_mac_cell (
  input  logic                   nvdla_core_clk,
  input  logic                   reset,
  input  cmac_pkg::cmac_actv_t   actv,
  output cmac_pkg::cmac_result_t result
);

  // raw signed products, one per channel
  logic signed [2*cmac_pkg::cmac_bpe-1:0] prod [cmac_pkg::cmac_atomc];
  // products with unused channels forced to zero
  logic signed [2*cmac_pkg::cmac_bpe-1:0] prod_m [cmac_pkg::cmac_atomc];
  // channel takes part only when both sides are nonzero
  cmac_pkg::cmac_mask_t                   ch_en;
  cmac_pkg::cmac_sum_t                    sum_w;

  // result registers
  cmac_pkg::cmac_sum_t                    sum_q;
  logic                                   pvld_q;
  logic                                   stripe_end_q;

  assign ch_en = actv.dat_nz & actv.wt_nz;

  // ====================
  // multiply
  // ====================

  always_comb begin
    for (int k = 0; k < cmac_pkg::cmac_atomc; k++) begin
      // both operands sign extend to the 16-bit product width
      prod[k] = $signed(actv.dat_data.ch[k]) * $signed(actv.wt_data.ch[k]);
    end
  end

  // stale data bytes behind a clear mask bit must not leak in
  always_comb begin
    for (int k = 0; k < cmac_pkg::cmac_atomc; k++) begin
      prod_m[k] = ch_en[k] ? prod[k] : '0;
    end
  end

  // ====================
  // sum
  // ====================

  // 8 x 16-bit into 19 bits, no overflow possible
  always_comb begin
    sum_w = '0;
    for (int k = 0; k < cmac_pkg::cmac_atomc; k++) begin
      sum_w = sum_w + cmac_pkg::cmac_sum_t'(prod_m[k]);
    end
  end

  // ====================
  // result stage
  // ====================

  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      pvld_q       <= 1'b0;
      stripe_end_q <= 1'b0;
    end else begin
      pvld_q       <= actv.pvld;
      // flag only rides on a valid result
      stripe_end_q <= actv.stripe_end & actv.pvld;
    end
  end

  // sum only moves on a valid atom
  always_ff @(posedge nvdla_core_clk) begin
    if (actv.pvld) begin
      sum_q <= sum_w;
    end
  end

  assign result = '{
    sum:        sum_q,
    pvld:       pvld_q,
    stripe_end: stripe_end_q
  };

endmodule

/* hw/cmac_pkg.sv */
// sizes are fixed at 8 channels, 8-bit signed elements and 4 cells; there is no precision mode
package cmac_pkg;

  // ====================
  // sizes
  // ====================

  // channels per atom
  localparam int cmac_atomc = 8;
  // bits per element
  localparam int cmac_bpe = 8;
  // mac cells in the core
  localparam int cmac_cells = 4;
  // 16-bit product plus 3 bits of growth over 8 channels
  localparam int cmac_sum_w = 19;

  // ====================
  // vector types
  // ====================

  // one signed element
  typedef logic signed [cmac_bpe-1:0] cmac_elem_t;
  // one bit per channel, 1 = channel holds a nonzero value
  typedef logic [cmac_atomc-1:0] cmac_mask_t;
  // one bit per mac cell
  typedef logic [cmac_cells-1:0] cmac_sel_t;
  // signed dot product of one atom
  typedef logic signed [cmac_sum_w-1:0] cmac_sum_t;

  // ====================
  // bundles
  // ====================

  // channel 0 sits in the low byte
  typedef struct packed {
    cmac_elem_t [cmac_atomc-1:0] ch;
  } cmac_atom_t;

  // data atom from the sequencer
  typedef struct packed {
    cmac_atom_t data;
    cmac_mask_t mask;
    logic       pvld;
    logic       stripe_st;
    logic       stripe_end;
  } cmac_dat_in_t;

  // weight atom, written to every cell whose sel bit is set
  typedef struct packed {
    cmac_atom_t data;
    cmac_mask_t mask;
    logic       pvld;
    cmac_sel_t  sel;
  } cmac_wt_in_t;

  // operands handed to one mac cell
  // pvld already includes the cell's active weight valid
  typedef struct packed {
    cmac_atom_t dat_data;
    cmac_mask_t dat_nz;
    cmac_atom_t wt_data;
    cmac_mask_t wt_nz;
    logic       pvld;
    logic       stripe_end;
  } cmac_actv_t;

  // registered output of one mac cell
  typedef struct packed {
    cmac_sum_t sum;
    logic      pvld;
    logic      stripe_end;
  } cmac_result_t;

endpackage

/* tests/tb_clock_gen.sv */
// free-running 4 ns clock; reset is held high for the first 10 rising edges, then dropped on a falling edge
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // release lands on a falling edge, like every other DUT input
  initial begin
    reset <= 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset <= 1'b0;
  end

endmodule

/* tests/tb_cmac_tasks.svh */
// included inside tb_cmac_core after the model; every test leaves the pipe drained behind it
`ifndef TB_CMAC_TASKS_SVH
`define TB_CMAC_TASKS_SVH

// ====================
// drive
// ====================

function automatic cmac_pkg::cmac_dat_in_t data_atom(input bytes_t bytes,
    input cmac_pkg::cmac_mask_t mask, input logic st, input logic last);
  return '{data: cmac_pkg::cmac_atom_t'(bytes), mask: mask, pvld: 1'b1,
           stripe_st: st, stripe_end: last};
endfunction

function automatic cmac_pkg::cmac_wt_in_t weight_atom(input bytes_t bytes,
    input cmac_pkg::cmac_mask_t mask, input cmac_pkg::cmac_sel_t sel);
  return '{data: cmac_pkg::cmac_atom_t'(bytes), mask: mask, pvld: 1'b1, sel: sel};
endfunction

// inputs change on the falling edge, the model takes the same values
task automatic drive_cycle(input cmac_pkg::cmac_dat_in_t dat, input cmac_pkg::cmac_wt_in_t wt);
  @(negedge clk);
  dat_in = dat;
  wt_in  = wt;
  model_step(dat, wt);
endtask

task automatic send_atom(input bytes_t bytes, input cmac_pkg::cmac_mask_t mask,
                         input logic st, input logic last);
  drive_cycle(data_atom(bytes, mask, st, last), '0);
endtask

task automatic load_weight(input bytes_t bytes, input cmac_pkg::cmac_mask_t mask,
                           input cmac_pkg::cmac_sel_t sel);
  drive_cycle('0, weight_atom(bytes, mask, sel));
endtask

task automatic idle_cycles(input int n);
  repeat (n) drive_cycle('0, '0);
endtask

// ====================
// compare
// ====================

task automatic check_sum(input string name, input cmac_pkg::cmac_sum_t got,
                         input cmac_pkg::cmac_sum_t want);
  if (got !== want) begin
    $display("FAIL %s: got %h, expected %h at cycle %0d", name, got, want, cyc);
    val_errs++;
  end
endtask

task automatic check_flag(input string name, input logic got, input logic want);
  if (got !== want) begin
    $display("FAIL %s: got %h, expected %h at cycle %0d", name, got, want, cyc);
    val_errs++;
  end
endtask

task automatic mark_counts();
  for (int i = 0; i < cmac_pkg::cmac_cells; i++) begin
    cnt_mark[i] = seen_cnt[i];
  end
endtask

// per-cell result counts since the last mark
task automatic expect_counts(input string test, input int n0, n1, n2, n3);
  int want [cmac_pkg::cmac_cells];
  want = '{n0, n1, n2, n3};
  for (int i = 0; i < cmac_pkg::cmac_cells; i++) begin
    if (seen_cnt[i] - cnt_mark[i] != want[i]) begin
      $display("ERROR %s: cell %0d gave %0d results where %0d were expected",
               test, i, seen_cnt[i] - cnt_mark[i], want[i]);
      other_errs++;
    end
  end
endtask

// ====================
// tests
// ====================

// first stripe has no weights anywhere, second has them in cell 3 only
task automatic reset_and_unloaded_cell();
  mark_counts();
  idle_cycles(4);
  send_atom(64'h0102_0304_0506_0708, 8'hff, 1'b1, 1'b0);
  send_atom(64'hf0e1_d2c3_b4a5_9687, 8'hff, 1'b0, 1'b1);
  load_weight(64'h7f80_01ff_2233_c4d5, 8'hff, 4'b1000);
  idle_cycles(1);
  send_atom(64'h1122_3344_5566_7788, 8'hff, 1'b1, 1'b0);
  send_atom(64'h8080_8080_7f7f_7f7f, 8'hff, 1'b0, 1'b0);
  send_atom(64'hff00_ff00_00ff_00ff, 8'hff, 1'b0, 1'b1);
  idle_cycles(5);
  expect_counts("unloaded cell", 0, 0, 0, 3);
endtask

task automatic basic_stripe();
  mark_counts();
  load_weight(64'h0102_0304_0506_0708, 8'hff, 4'b0001);
  load_weight(64'hfffe_fdfc_fbfa_f9f8, 8'hff, 4'b0010);
  load_weight(64'h8080_8080_8080_8080, 8'hff, 4'b0100);
  load_weight(64'h7f81_7f81_107f_e003, 8'hff, 4'b1000);
  idle_cycles(1);
  send_atom(64'h1020_3040_5060_7080, 8'hff, 1'b1, 1'b0);
  send_atom(64'h8080_8080_8080_8080, 8'hff, 1'b0, 1'b0);
  send_atom(64'hc3a5_5a3c_0ff0_7e81, 8'hff, 1'b0, 1'b1);
  idle_cycles(5);
  expect_counts("basic stripe", 3, 3, 3, 3);
endtask

// stale bytes sit behind clear mask bits in both the data and the shadow
task automatic masked_channels();
  mark_counts();
  load_weight(64'h1111_2222_3333_4444, 8'hff, 4'b1111);
  load_weight(64'h9abc_def0_8765_4321, 8'h5a, 4'b0011);
  idle_cycles(1);
  send_atom(64'h7f7f_7f7f_8080_8080, 8'hff, 1'b1, 1'b0);
  send_atom(64'h0102_0304_0506_0708, 8'h3c, 1'b0, 1'b0);
  send_atom(64'hdead_beef_cafe_f00d, 8'h81, 1'b0, 1'b1);
  idle_cycles(5);
  expect_counts("masking", 3, 3, 3, 3);
endtask

// new weights for cells 0 and 2 arrive mid-stripe and wait for the next one
task automatic shadow_isolation();
  mark_counts();
  load_weight(64'h0203_0405_0607_0809, 8'hff, 4'b1111);
  idle_cycles(1);
  send_atom(64'h1010_2020_3030_4040, 8'hff, 1'b1, 1'b0);
  drive_cycle(data_atom(64'h0f0e_0d0c_0b0a_0908, 8'hff, 1'b0, 1'b0),
              weight_atom(64'hf1f2_f3f4_0506_0708, 8'hff, 4'b0101));
  send_atom(64'h8899_aabb_ccdd_eeff, 8'hff, 1'b0, 1'b1);
  send_atom(64'h1234_5678_9abc_def0, 8'hff, 1'b1, 1'b0);
  send_atom(64'h7f80_7f80_7f80_7f80, 8'hff, 1'b0, 1'b0);
  send_atom(64'h0101_0101_0101_0101, 8'hff, 1'b0, 1'b1);
  idle_cycles(5);
  expect_counts("shadow isolation", 6, 3, 6, 3);
endtask

// back-to-back stripes of 1 to 4 atoms, weights may land on any cycle
task automatic random_stripes();
  int                     len;
  cmac_pkg::cmac_dat_in_t dat;
  cmac_pkg::cmac_wt_in_t  wt;
  load_weight(rand_bits($bits(bytes_t)), 8'hff, 4'b1111);
  idle_cycles(1);
  for (int s = 0; s < 12; s++) begin
    len = int'(rand_bits(2)) + 1;
    for (int a = 0; a < len; a++) begin
      dat      = data_atom(rand_bits($bits(bytes_t)), '1, a == 0, a == len - 1);
      dat.mask = cmac_pkg::cmac_mask_t'(rand_bits(8));
      wt       = weight_atom(rand_bits($bits(bytes_t)), '1, '1);
      wt.mask  = cmac_pkg::cmac_mask_t'(rand_bits(8));
      wt.sel   = cmac_pkg::cmac_sel_t'(rand_bits(4));
      wt.pvld  = lfsr_bit();
      drive_cycle(dat, wt);
    end
  end
  idle_cycles(5);
endtask

`endif

/* tests/tb_cmac_core.sv */
// expects a data-to-result latency of 3 edges; the cycle model trusts the weight ordering rule
`timescale 1ns/100ps

module tb_cmac_core;

  // ====================
  // run limits
  // ====================

  // rough cycle lengths of the tests, these set the timeout
  localparam int len_unloaded = 20;
  localparam int len_basic    = 16;
  localparam int len_masked   = 16;
  localparam int len_shadow   = 20;
  localparam int len_random   = 64;
  localparam int max_cycles   = 2 * (len_unloaded + len_basic + len_masked
                                     + len_shadow + len_random) + 100;
  // atom driven in cycle c is a result after edge c+3
  localparam int latency      = 3;

  typedef logic [cmac_pkg::cmac_atomc*cmac_pkg::cmac_bpe-1:0] bytes_t;

  // one predicted result
  typedef struct packed {
    int                  due;
    cmac_pkg::cmac_sum_t sum;
    logic                stripe_end;
  } exp_t;

  logic                   clk;
  logic                   reset;
  cmac_pkg::cmac_dat_in_t dat_in;
  cmac_pkg::cmac_wt_in_t  wt_in;
  cmac_pkg::cmac_result_t result [cmac_pkg::cmac_cells];

  // rising edges seen so far
  int          cyc = 0;
  int          val_errs = 0;
  int          other_errs = 0;
  int          checked = 0;
  int          seen_cnt [cmac_pkg::cmac_cells];
  int          cnt_mark [cmac_pkg::cmac_cells];
  logic [31:0] lfsr = 32'h916e3b42;

  // model of the shadow and active weight sets
  cmac_pkg::cmac_atom_t sd_data [cmac_pkg::cmac_cells];
  cmac_pkg::cmac_mask_t sd_nz [cmac_pkg::cmac_cells];
  logic                 sd_vld [cmac_pkg::cmac_cells];
  cmac_pkg::cmac_atom_t act_data [cmac_pkg::cmac_cells];
  cmac_pkg::cmac_mask_t act_nz [cmac_pkg::cmac_cells];
  logic                 act_vld [cmac_pkg::cmac_cells];
  exp_t                 exp_q [cmac_pkg::cmac_cells][$];

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  cmac_core i_cmac_core (
    .nvdla_core_clk (clk),
    .reset          (reset),
    .dat_in         (dat_in),
    .wt_in          (wt_in),
    .result         (result)
  );

  // ====================
  // random bits
  // ====================

  // galois form, one step per bit handed out
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h80200003;
    end
    return b;
  endfunction

  function automatic bytes_t rand_bits(input int n);
    bytes_t v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v[b] = lfsr_bit();
    end
    return v;
  endfunction

  // ====================
  // reference model
  // ====================

  // one sampling edge: stripe start copy, then the result, then the new weight
  function automatic void model_step(input cmac_pkg::cmac_dat_in_t dat,
                                     input cmac_pkg::cmac_wt_in_t wt);
    int acc;
    for (int i = 0; i < cmac_pkg::cmac_cells; i++) begin
      if (dat.pvld) begin
        if (dat.stripe_st) begin
          act_vld[i] = sd_vld[i];
          if (sd_vld[i]) begin
            act_data[i] = sd_data[i];
            act_nz[i]   = sd_nz[i];
          end
          sd_vld[i] = 1'b0;
        end
        if (act_vld[i]) begin
          acc = 0;
          // only channels with both masks set count
          for (int k = 0; k < cmac_pkg::cmac_atomc; k++) begin
            if (dat.mask[k] && act_nz[i][k]) begin
              acc += int'(dat.data.ch[k]) * int'(act_data[i].ch[k]);
            end
          end
          exp_q[i].push_back('{due: cyc + latency, sum: cmac_pkg::cmac_sum_t'(acc),
                               stripe_end: dat.stripe_end});
        end
        // weights die after the last atom unless the next one restarts
        if (dat.stripe_end) begin
          act_vld[i] = 1'b0;
        end
      end
      if (wt.pvld && wt.sel[i]) begin
        for (int k = 0; k < cmac_pkg::cmac_atomc; k++) begin
          if (wt.mask[k]) begin
            sd_data[i].ch[k] = wt.data.ch[k];
          end
        end
        sd_nz[i]  = wt.mask;
        sd_vld[i] = 1'b1;
      end
    end
  endfunction

  `include "tb_cmac_tasks.svh"

  // ====================
  // monitor and limits
  // ====================

  always @(negedge clk) begin
    exp_t e;
    if (!reset) begin
      for (int i = 0; i < cmac_pkg::cmac_cells; i++) begin
        if (exp_q[i].size() > 0 && exp_q[i][0].due == cyc) begin
          e = exp_q[i].pop_front();
          if (!result[i].pvld) begin
            $display("ERROR cell %0d: result due at cycle %0d never came", i, cyc);
            other_errs++;
          end else begin
            check_sum($sformatf("result[%0d].sum", i), result[i].sum, e.sum);
            check_flag($sformatf("result[%0d].stripe_end", i), result[i].stripe_end,
                       e.stripe_end);
            seen_cnt[i]++;
            checked++;
          end
        end else begin
          check_flag($sformatf("result[%0d].pvld", i), result[i].pvld, 1'b0);
        end
      end
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  always @(posedge clk) begin
    if (cyc >= max_cycles) begin
      $display("ERROR: run still going after %0d cycles", max_cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    dat_in = '0;
    wt_in  = '0;
    for (int i = 0; i < cmac_pkg::cmac_cells; i++) begin
      sd_vld[i]   = 1'b0;
      act_vld[i]  = 1'b0;
      seen_cnt[i] = 0;
      cnt_mark[i] = 0;
    end
    @(negedge clk);
    while (reset) @(negedge clk);
    reset_and_unloaded_cell();
    basic_stripe();
    masked_channels();
    shadow_isolation();
    random_stripes();
    for (int i = 0; i < cmac_pkg::cmac_cells; i++) begin
      if (exp_q[i].size() != 0) begin
        $display("ERROR cell %0d: %0d results still pending at the end", i, exp_q[i].size());
        other_errs++;
      end
    end
    $display("summary: %0d value errors, %0d other errors, %0d results checked",
             val_errs, other_errs, checked);
    if (val_errs + other_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
